//--- include/pio_params.svh
// PIO bus widths, table region bit and the two table sizes
`ifndef PIO_PARAMS_SVH
`define PIO_PARAMS_SVH

// PIO data bus
`define PIO_NBITS 32

// Byte address, both tables together
`define PIO_ADDR_NBITS 14

// Address bit that selects table A (0) or B (1)
`define PIO_REGION_BIT 13

// Table A, 1024 entries of 50 bits
`define TBL_A_WIDTH 50
`define TBL_A_DEPTH_NBITS 10

// Table B, 256 entries of 64 bits
`define TBL_B_WIDTH 64
`define TBL_B_DEPTH_NBITS 8

`endif

//--- rtl/pio_pkg.sv
// PIO address union, request struct and response struct
package pio_pkg;

	`include "pio_params.svh"

	// Address seen as dword index plus byte bits
	typedef struct packed {
		logic [`PIO_ADDR_NBITS-3:0] dw_idx; // Bit 0 picks low/high half
		logic [1:0]                 byte_sel;
	} pio_addr_dw_t;

	// Address seen as region, entry and half
	typedef struct packed {
		logic                       region;   // 0 table A, 1 table B
		logic [`PIO_REGION_BIT-4:0] entry;    // Table B uses the low bits only
		logic                       half;     // 1 = upper dword
		logic [1:0]                 byte_sel;
	} pio_addr_ent_t;

	// One address word, two decodes
	typedef union packed {
		pio_addr_dw_t  dw;
		pio_addr_ent_t ent;
	} pio_addr_u;

	typedef struct packed {
		pio_addr_u             addr;
		logic [`PIO_NBITS-1:0] wdata;
		logic                  rd;  // One-cycle pulse
		logic                  wr;  // One-cycle pulse
		logic                  sel; // Access is for this block
	} pio_req_t;

	typedef struct packed {
		logic                  ack;   // Paced by pio_tick
		logic [`PIO_NBITS-1:0] rdata; // Held while ack high
	} pio_rsp_t;

endpackage

//--- rtl/ram_1r1w.sv
// Simple dual-port RAM with one registered read port and one write port
`timescale 1ns/1ns

module ram_1r1w #(
	parameter int WIDTH       = 50,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                   clk,
	input  logic                   wr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  logic [WIDTH-1:0]       din,
	output logic [WIDTH-1:0]       dout
);

	// Storage, no init
	logic [WIDTH-1:0] mem [0:(1<<DEPTH_NBITS)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// Registered read
	// Same-address write in the same cycle gives the old word
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

//--- rtl/pio_wmem.sv
// PIO-accessible wide memory with dword staging, read arbitration and ack pacing
`timescale 1ns/1ns

`include "pio_params.svh"

module pio_wmem #(
	parameter int WIDTH       = 50,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   pio_tick,  // Slow-clock strobe
	input  pio_pkg::pio_req_t      req,
	output pio_pkg::pio_rsp_t      rsp,
	input  logic                   app_rd,
	input  logic [DEPTH_NBITS-1:0] app_raddr,
	output logic                   app_ack,
	output logic [WIDTH-1:0]       app_rdata
);

	localparam int HI_NBITS = WIDTH - `PIO_NBITS; // Upper part of an entry

	logic [DEPTH_NBITS-1:0] pio_entry;
	logic                   pio_half;
	logic                   wr_lo;
	logic                   wr_hi;
	logic                   rd_lo;
	logic                   rd_hi;

	logic                   app_rd_d1;   // App read in RAM address stage
	logic                   app_rd_d2;
	logic [DEPTH_NBITS-1:0] app_raddr_d1;

	logic                   lo_save;     // Low read lost to an app read
	logic [DEPTH_NBITS-1:0] lo_save_addr;
	logic                   lo_pend;
	logic                   lo_go;       // Low read owns the RAM port
	logic                   lo_go_d1;    // Its data is on ram_rdata

	logic [`PIO_NBITS-1:0]  wdata_lo;    // Staged low dword
	logic [HI_NBITS-1:0]    hold_hi;     // Upper part from last low read
	logic [`PIO_NBITS-1:0]  hold_hi_ext;

	logic                   pend;        // Access done, waiting for tick
	logic                   ack_q;
	logic [`PIO_NBITS-1:0]  rdata_q;

	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [WIDTH-1:0]       ram_wdata;
	logic [WIDTH-1:0]       ram_rdata;

	// Entry from the entry view, half from the dword index
	assign pio_entry = req.addr.ent.entry[DEPTH_NBITS-1:0];
	assign pio_half  = req.addr.dw.dw_idx[0];

	assign wr_lo = req.sel & req.wr & ~pio_half;
	assign wr_hi = req.sel & req.wr &  pio_half;
	assign rd_lo = req.sel & req.rd & ~pio_half;
	assign rd_hi = req.sel & req.rd &  pio_half;

	// App read wins the port, PIO low read waits
	assign lo_pend = rd_lo | lo_save;
	assign lo_go   = lo_pend & ~app_rd_d1;

	always_comb begin
		if (app_rd_d1)
			ram_raddr = app_raddr_d1;
		else if (lo_save)
			ram_raddr = lo_save_addr; // Retry of the lost read
		else
			ram_raddr = pio_entry;
	end

	// High write commits the whole entry, extra bits dropped
	assign ram_wdata = {req.wdata[HI_NBITS-1:0], wdata_lo};

	always_comb begin
		hold_hi_ext = '0;
		hold_hi_ext[HI_NBITS-1:0] = hold_hi; // Zero-filled above WIDTH
	end

	ram_1r1w #(
		.WIDTH       (WIDTH),
		.DEPTH_NBITS (DEPTH_NBITS)
	) u_ram (
		.clk   (clk),
		.wr    (wr_hi),
		.waddr (pio_entry),
		.raddr (ram_raddr),
		.din   (ram_wdata),
		.dout  (ram_rdata)
	);

	// Payload, no reset
	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_raddr;
		app_rdata    <= ram_rdata;
		if (rd_lo)
			lo_save_addr <= pio_entry;
		if (wr_lo)
			wdata_lo <= req.wdata;
		if (lo_go_d1) begin
			rdata_q <= ram_rdata[`PIO_NBITS-1:0];
			hold_hi <= ram_rdata[WIDTH-1:`PIO_NBITS];
		end else if (rd_hi) begin
			rdata_q <= hold_hi_ext; // Upper part kept from the low read
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_ack   <= 1'b0;
			lo_save   <= 1'b0;
			lo_go_d1  <= 1'b0;
			pend      <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			app_rd_d1 <= app_rd;
			app_rd_d2 <= app_rd_d1;
			app_ack   <= app_rd_d2;         // t+3 after app_rd
			lo_save   <= lo_pend & app_rd_d1; // Held until the port is free
			lo_go_d1  <= lo_go;
			if (wr_lo | wr_hi | rd_hi | lo_go_d1)
				pend <= 1'b1;
			else if (pio_tick)
				pend <= 1'b0;
			if (pio_tick)
				ack_q <= pend;                // Rise and fall on tick
		end
	end

	assign rsp = '{ack: ack_q, rdata: rdata_q};

	// Ack edges are only taken on a tick
	a_ack_on_tick: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack_q) |-> $past(pio_tick));

	// Fixed app read latency
	a_app_lat: assert property (@(posedge clk) disable iff (!arst_n)
		app_rd |-> ##3 app_ack);

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(req.rd && req.wr));

endmodule

//--- rtl/pio_port.sv
// PIO region decode toward the two tables and merge of their responses
`timescale 1ns/1ns

module pio_port (
	input  pio_pkg::pio_req_t req,
	output pio_pkg::pio_rsp_t rsp,
	output pio_pkg::pio_req_t req_a,
	output pio_pkg::pio_req_t req_b,
	input  pio_pkg::pio_rsp_t rsp_a,
	input  pio_pkg::pio_rsp_t rsp_b
);

	logic region; // Region bit of the current access

	assign region = req.addr.ent.region;

	// Both tables see the access, only one is selected
	always_comb begin
		req_a     = req;
		req_a.sel = req.sel & ~region;
		req_b     = req;
		req_b.sel = req.sel & region;
	end

	// Only one access outstanding, so at most one ack
	always_comb begin
		rsp.ack = rsp_a.ack | rsp_b.ack;
		if (rsp_b.ack)
			rsp.rdata = rsp_b.rdata;
		else
			rsp.rdata = rsp_a.rdata; // Table A or idle
	end

	// Tables never answer at once
	always_comb begin
		a_one_ack: assert (!(rsp_a.ack && rsp_b.ack))
			else $error("both tables acked");
	end

endmodule

//--- rtl/wmem_subsys_top.sv
// Wide-memory subsystem top with the PIO port and tables A and B
`timescale 1ns/1ns

`include "pio_params.svh"

module wmem_subsys_top (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          pio_tick,
	input  pio_pkg::pio_req_t             pio_req,
	output pio_pkg::pio_rsp_t             pio_rsp,
	input  logic                          app_a_rd,
	input  logic [`TBL_A_DEPTH_NBITS-1:0] app_a_raddr,
	output logic                          app_a_ack,
	output logic [`TBL_A_WIDTH-1:0]       app_a_rdata,
	input  logic                          app_b_rd,
	input  logic [`TBL_B_DEPTH_NBITS-1:0] app_b_raddr,
	output logic                          app_b_ack,
	output logic [`TBL_B_WIDTH-1:0]       app_b_rdata
);

	pio_pkg::pio_req_t req_a;
	pio_pkg::pio_req_t req_b;
	pio_pkg::pio_rsp_t rsp_a;
	pio_pkg::pio_rsp_t rsp_b;

	// Combinational, no added latency
	pio_port u_pio_port (
		.req   (pio_req),
		.rsp   (pio_rsp),
		.req_a (req_a),
		.req_b (req_b),
		.rsp_a (rsp_a),
		.rsp_b (rsp_b)
	);

	// Table A, 50 x 1024
	pio_wmem #(
		.WIDTH       (`TBL_A_WIDTH),
		.DEPTH_NBITS (`TBL_A_DEPTH_NBITS)
	) u_tbl_a (
		.clk       (clk),
		.arst_n    (arst_n),
		.pio_tick  (pio_tick),
		.req       (req_a),
		.rsp       (rsp_a),
		.app_rd    (app_a_rd),
		.app_raddr (app_a_raddr),
		.app_ack   (app_a_ack),
		.app_rdata (app_a_rdata)
	);

	// Table B, 64 x 256
	pio_wmem #(
		.WIDTH       (`TBL_B_WIDTH),
		.DEPTH_NBITS (`TBL_B_DEPTH_NBITS)
	) u_tbl_b (
		.clk       (clk),
		.arst_n    (arst_n),
		.pio_tick  (pio_tick),
		.req       (req_b),
		.rsp       (rsp_b),
		.app_rd    (app_b_rd),
		.app_raddr (app_b_raddr),
		.app_ack   (app_b_ack),
		.app_rdata (app_b_rdata)
	);

endmodule

//--- testbench/tb_wmem_subsys.sv
// Testbench for the wide-memory subsystem with clock, tick, LFSR, table models and directed tests
`timescale 1ns/1ns

`include "pio_params.svh"

module tb_wmem_subsys;
	import pio_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000; // About 4x the summed test lengths

	logic clk;
	logic arst_n;
	logic pio_tick;
	logic [1:0] tick_cnt;
	int cycle_cnt;
	logic [31:0] lfsr;
	pio_req_t pio_req;
	pio_rsp_t pio_rsp;
	logic app_a_rd;
	logic [`TBL_A_DEPTH_NBITS-1:0] app_a_raddr;
	logic app_a_ack;
	logic [`TBL_A_WIDTH-1:0] app_a_rdata;
	logic app_b_rd;
	logic [`TBL_B_DEPTH_NBITS-1:0] app_b_raddr;
	logic app_b_ack;
	logic [`TBL_B_WIDTH-1:0] app_b_rdata;

	// Reference tables and the entries written so far
	logic [`TBL_A_WIDTH-1:0] model_a [0:(1<<`TBL_A_DEPTH_NBITS)-1];
	logic [`TBL_B_WIDTH-1:0] model_b [0:(1<<`TBL_B_DEPTH_NBITS)-1];
	logic [9:0] wr_a_q [$];
	logic [7:0] wr_b_q [$];

	wmem_subsys_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		pio_tick = (tick_cnt == 2'd3); // One cycle in four
		tick_cnt = tick_cnt + 2'd1;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// Galois LFSR, x^32+x^22+x^2+x+1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[62:0], lfsr_bit()}; // One step per bit
		return r;
	endfunction

	task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("Test failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_rsp(input string name, input pio_rsp_t got, input pio_rsp_t exp);
		if (got.rdata !== exp.rdata)
			fail_value(name, 64'(got.rdata), 64'(exp.rdata));
	endtask

	task automatic check_entry_a(input string name, input logic [`TBL_A_WIDTH-1:0] got,
		input logic [`TBL_A_WIDTH-1:0] exp);
		if (got !== exp)
			fail_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_entry_b(input string name, input logic [`TBL_B_WIDTH-1:0] got,
		input logic [`TBL_B_WIDTH-1:0] exp);
		if (got !== exp)
			fail_value(name, got, exp);
	endtask

	// One bus access, returns the response seen while ack is high
	task automatic pio_access(input logic region, input logic [9:0] entry, input logic half,
		input logic is_wr, input logic [31:0] wdata, output pio_rsp_t rsp);
		pio_addr_u addr;
		addr = '0;
		addr.ent.region = region;
		addr.ent.entry = entry;
		addr.ent.half = half;
		pio_req = '{addr: addr, wdata: wdata, rd: !is_wr, wr: is_wr, sel: 1'b1};
		@(posedge clk);
		#1;
		pio_req.rd = 1'b0; // Strobes are single-cycle
		pio_req.wr = 1'b0;
		pio_req.sel = 1'b0;
		while (!pio_rsp.ack) begin
			@(posedge clk);
			#1;
		end
		rsp = pio_rsp;
		while (pio_rsp.ack) begin // Wait for ack to fall before the next access
			@(posedge clk);
			#1;
		end
	endtask

	task automatic pio_write_entry(input logic region, input logic [9:0] entry,
		input logic [63:0] data);
		pio_rsp_t rsp;
		pio_access(region, entry, 1'b0, 1'b1, data[31:0], rsp);
		pio_access(region, entry, 1'b1, 1'b1, data[63:32], rsp);
		if (region)
			model_b[entry[7:0]] = data;
		else
			model_a[entry] = data[`TBL_A_WIDTH-1:0]; // Bits above the width dropped
	endtask

	task automatic pio_read_check(input logic region, input logic [9:0] entry);
		logic [63:0] ent;
		pio_rsp_t rsp;
		pio_rsp_t exp;
		if (region)
			ent = model_b[entry[7:0]];
		else
			ent = 64'(model_a[entry]); // Zero above the width
		exp = '0;
		exp.ack = 1'b1;
		exp.rdata = ent[31:0];
		pio_access(region, entry, 1'b0, 1'b0, 32'h0, rsp);
		check_rsp("pio_rsp.rdata low", rsp, exp);
		exp.rdata = ent[63:32];
		pio_access(region, entry, 1'b1, 1'b0, 32'h0, rsp);
		check_rsp("pio_rsp.rdata high", rsp, exp);
	endtask

	// Back-to-back app reads on both tables, acks expected 3 cycles after each read
	task automatic app_read_burst(input logic [9:0] qa [$], input logic [7:0] qb [$]);
		logic [9:0] ea [$];
		logic [7:0] eb [$];
		logic [9:0] ia;
		logic [7:0] ib;
		int n;
		n = qa.size();
		for (int c = 0; c < n + 4; c++) begin
			check_bit("app_a_ack", app_a_ack, (c >= 3) && (c < n + 3));
			check_bit("app_b_ack", app_b_ack, (c >= 3) && (c < n + 3));
			if (app_a_ack) begin
				ia = ea.pop_front();
				check_entry_a("app_a_rdata", app_a_rdata, model_a[ia]);
			end
			if (app_b_ack) begin
				ib = eb.pop_front();
				check_entry_b("app_b_rdata", app_b_rdata, model_b[ib]);
			end
			app_a_rd = (c < n);
			app_b_rd = (c < n);
			if (c < n) begin
				app_a_raddr = qa[c];
				app_b_raddr = qb[c];
				ea.push_back(qa[c]);
				eb.push_back(qb[c]);
			end
			@(posedge clk);
			#1;
		end
	endtask

	task automatic test_reset_idle();
		repeat (8) begin
			check_bit("pio_rsp.ack", pio_rsp.ack, 1'b0);
			check_bit("app_a_ack", app_a_ack, 1'b0);
			check_bit("app_b_ack", app_b_ack, 1'b0);
			@(posedge clk);
			#1;
		end
	endtask

	task automatic test_pio_write_read();
		logic [63:0] r;
		for (int i = 0; i < 64; i++) begin
			r = rand_bits(10);
			wr_a_q.push_back(r[9:0]);
			pio_write_entry(1'b0, r[9:0], rand_bits(64));
			r = rand_bits(8);
			wr_b_q.push_back(r[7:0]);
			pio_write_entry(1'b1, {2'b00, r[7:0]}, rand_bits(64));
		end
		for (int i = 0; i < 64; i++) begin // Repeated entries read the last write
			pio_read_check(1'b0, wr_a_q[i]);
			pio_read_check(1'b1, {2'b00, wr_b_q[i]});
		end
	endtask

	task automatic test_app_reads();
		app_read_burst(wr_a_q[16:31], wr_b_q[16:31]);
	endtask

	// Table A writes whose low entry bits alias table B entries
	task automatic test_isolation();
		logic [9:0] qa [$];
		logic [63:0] r;
		for (int i = 0; i < 16; i++) begin
			r = rand_bits(2);
			qa.push_back({r[1:0], wr_b_q[i]});
			pio_write_entry(1'b0, {r[1:0], wr_b_q[i]}, rand_bits(64));
		end
		app_read_burst(qa, wr_b_q[0:15]);
	endtask

	task automatic test_staging();
		logic [9:0] e;
		logic [63:0] lo_x;
		logic [63:0] lo_y;
		logic [63:0] hi;
		logic [63:0] ent;
		pio_rsp_t rsp;
		e = wr_a_q[0];
		lo_x = rand_bits(32);
		lo_y = rand_bits(32);
		hi = rand_bits(32);
		pio_access(1'b0, e, 1'b0, 1'b1, lo_x[31:0], rsp); // Staged only
		app_read_burst(wr_a_q[0:0], wr_b_q[0:0]);
		pio_access(1'b0, e ^ 10'd1, 1'b0, 1'b1, lo_y[31:0], rsp);
		pio_access(1'b0, e, 1'b1, 1'b1, hi[31:0], rsp);
		ent = {hi[31:0], lo_y[31:0]}; // Last staged low dword wins
		model_a[e] = ent[`TBL_A_WIDTH-1:0];
		pio_read_check(1'b0, e);
	endtask

	// PIO low read alongside back-to-back app reads on table A
	task automatic test_collision();
		fork
			app_read_burst(wr_a_q[2:3], wr_b_q[2:3]);
			begin
				@(posedge clk);
				#1;
				pio_read_check(1'b0, wr_a_q[1]);
			end
		join
	endtask

	initial begin
		arst_n = 1'b0;
		pio_tick = 1'b0;
		tick_cnt = 2'd0;
		cycle_cnt = 0;
		lfsr = 32'h778f_53c4;
		pio_req = '0;
		app_a_rd = 1'b0;
		app_a_raddr = '0;
		app_b_rd = 1'b0;
		app_b_raddr = '0;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset_idle();
		test_pio_write_read();
		test_app_reads();
		test_isolation();
		test_staging();
		test_collision();
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
rtl/pio_pkg.sv
rtl/ram_1r1w.sv
rtl/pio_wmem.sv
rtl/pio_port.sv
rtl/wmem_subsys_top.sv
testbench/tb_wmem_subsys.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
	-f filelist.f --top-module tb_wmem_subsys -Mdir obj_dir
./obj_dir/Vtb_wmem_subsys
